//--- Bender.yml
package:
  name: issue_front

export_include_dirs:
  - include

sources:
  # packages before their users
  - hw/isa_pkg.sv
  - hw/issue_pkg.sv
  - hw/instr_decoder.sv
  - hw/re_name.sv
  - hw/pending_tracker.sv
  - hw/issue_front.sv
  - target: test
    files:
      - tests/issue_front_props.sv
      - tests/issue_front_tb.sv

//--- hw/instr_decoder.sv
// purely combinational; only opcode and funct7 are checked, funct3/rm/fmt are not validated
`default_nettype none

`include "issue_params.svh"

module instr_decoder (
    input  isa_pkg::instr_word_t        instr_i,
    output issue_pkg::op_class_e        op_o,
    output logic [`ISSUE_AREG_W-1:0]    rs1_o,
    output logic [`ISSUE_AREG_W-1:0]    rs2_o,
    output logic [`ISSUE_AREG_W-1:0]    rs3_o,
    output logic [`ISSUE_AREG_W-1:0]    rd_o,
    output logic                        rs1_fpr_o,
    output logic                        rs2_fpr_o,
    output logic                        rd_fpr_o,
    output logic                        uses_rs3_o,
    output logic                        writes_rd_o
);

    // opcode sits at the same place in both formats
    logic [6:0] opcode;
    logic [6:0] funct7;

    assign opcode = instr_i.r.opcode;
    // only meaningful in the register view
    assign funct7 = instr_i.r.funct7;

    // ------------------------------
    // class and operand decode
    // ------------------------------
    always_comb begin
        // defaults describe an illegal word
        // integer selects, no write, no third source
        // rs1, rs2 and rd sit at the same place in both formats
        op_o        = issue_pkg::OPC_ILLEGAL;
        rs1_o       = instr_i.r.rs1;
        rs2_o       = instr_i.r.rs2;
        rs3_o       = '0;
        rd_o        = instr_i.r.rd;
        rs1_fpr_o   = 1'b0;
        rs2_fpr_o   = 1'b0;
        rd_fpr_o    = 1'b0;
        uses_rs3_o  = 1'b0;
        writes_rd_o = 1'b0;

        case (opcode)
            isa_pkg::OPC_OP: begin
                // all operands in the integer file
                op_o        = issue_pkg::OPC_INT_RR;
                writes_rd_o = 1'b1;
            end

            isa_pkg::OPC_OP_FP: begin
                writes_rd_o = 1'b1;
                if (funct7 == isa_pkg::FN7_FMV_X_W) begin
                    // sources from FP, result into integer
                    op_o      = issue_pkg::OPC_FP_TO_INT;
                    rs1_fpr_o = 1'b1;
                    rs2_fpr_o = 1'b1;
                end else if (funct7 == isa_pkg::FN7_FMV_W_X) begin
                    // sources from integer, result into FP
                    op_o      = issue_pkg::OPC_INT_TO_FP;
                    rd_fpr_o  = 1'b1;
                end else begin
                    // any other funct7 is plain FP arithmetic
                    op_o      = issue_pkg::OPC_FP_RR;
                    rs1_fpr_o = 1'b1;
                    rs2_fpr_o = 1'b1;
                    rd_fpr_o  = 1'b1;
                end
            end

            isa_pkg::OPC_FMADD: begin
                // fused view, rs3 replaces funct7
                op_o        = issue_pkg::OPC_FP_FMA;
                rs3_o       = instr_i.r4.rs3;
                rs1_fpr_o   = 1'b1;
                rs2_fpr_o   = 1'b1;
                rd_fpr_o    = 1'b1;
                uses_rs3_o  = 1'b1;
                writes_rd_o = 1'b1;
            end

            default: begin
                // unknown opcode, keep the illegal defaults
                op_o = issue_pkg::OPC_ILLEGAL;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/isa_pkg.sv
// covers only the R and R4 formats; immediate formats and compressed words are not described
`default_nettype none

`include "issue_params.svh"

package isa_pkg;

    // ------------------------------
    // major opcodes
    // ------------------------------

    // integer register-register
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    // FP register-register, also carries the FP moves
    localparam logic [6:0] OPC_OP_FP = 7'b1010011;
    // fused multiply-add, three FP sources
    localparam logic [6:0] OPC_FMADD = 7'b1000011;

    // funct7 inside OPC_OP_FP that picks the moves
    // fmv.x.w, FP register into integer register
    localparam logic [6:0] FN7_FMV_X_W = 7'b1110000;
    // fmv.w.x, integer register into FP register
    localparam logic [6:0] FN7_FMV_W_X = 7'b1111000;

    // ------------------------------
    // instruction formats
    // ------------------------------

    // register format
    typedef struct packed {
        logic [6:0]               funct7;
        logic [`ISSUE_AREG_W-1:0] rs2;
        logic [`ISSUE_AREG_W-1:0] rs1;
        logic [2:0]               funct3;
        logic [`ISSUE_AREG_W-1:0] rd;
        logic [6:0]               opcode;
    } instr_r_t;

    // fused format, rs3 sits where funct7 is in the register format
    typedef struct packed {
        logic [`ISSUE_AREG_W-1:0] rs3;
        logic [1:0]               fmt;
        logic [`ISSUE_AREG_W-1:0] rs2;
        logic [`ISSUE_AREG_W-1:0] rs1;
        logic [2:0]               rm;
        logic [`ISSUE_AREG_W-1:0] rd;
        logic [6:0]               opcode;
    } instr_r4_t;

    // one 32-bit word, read as either format
    typedef union packed {
        instr_r_t  r;
        instr_r4_t r4;
    } instr_word_t;

endpackage

`default_nettype wire

//--- hw/issue_front.sv
// no handshake of its own; valid and ack pass through, readiness is combinational from instr_i
`default_nettype none

`include "issue_params.svh"

module issue_front (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  isa_pkg::instr_word_t    instr_i,
    input  logic                    instr_valid_i,
    input  logic                    issue_ack_i,
    input  logic                    flush_i,
    input  logic                    flush_unissued_i,
    input  logic                    wb_valid_i,
    input  issue_pkg::preg_t        wb_preg_i,
    input  logic                    wb_fpr_i,
    output issue_pkg::op_class_e    op_o,
    output issue_pkg::preg_t        prs1_o,
    output issue_pkg::preg_t        prs2_o,
    output issue_pkg::preg_t        prs3_o,
    output issue_pkg::preg_t        prd_o,
    output logic                    issue_valid_o,
    output logic                    issue_ack_o,
    output logic                    rs1_ready_o,
    output logic                    rs2_ready_o,
    output logic                    rs3_ready_o
);

    // ------------------------------
    // decoder outputs
    // ------------------------------
    logic [`ISSUE_AREG_W-1:0] rs1, rs2, rs3, rd;
    logic rs1_fpr, rs2_fpr, rd_fpr;
    logic uses_rs3, writes_rd;

    instr_decoder instr_decoder_inst (
        .instr_i     (instr_i),
        .op_o        (op_o),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rs3_o       (rs3),
        .rd_o        (rd),
        .rs1_fpr_o   (rs1_fpr),
        .rs2_fpr_o   (rs2_fpr),
        .rd_fpr_o    (rd_fpr),
        .uses_rs3_o  (uses_rs3),
        .writes_rd_o (writes_rd)
    );

    // renamed addresses also feed the tracker
    re_name re_name_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .flush_unissued_i (flush_unissued_i),
        .instr_valid_i    (instr_valid_i),
        .issue_ack_i      (issue_ack_i),
        .writes_rd_i      (writes_rd),
        .uses_rs3_i       (uses_rs3),
        .rs1_fpr_i        (rs1_fpr),
        .rs2_fpr_i        (rs2_fpr),
        .rd_fpr_i         (rd_fpr),
        .rs1_i            (rs1),
        .rs2_i            (rs2),
        .rs3_i            (rs3),
        .rd_i             (rd),
        .prs1_o           (prs1_o),
        .prs2_o           (prs2_o),
        .prs3_o           (prs3_o),
        .prd_o            (prd_o),
        .issue_valid_o    (issue_valid_o),
        .issue_ack_o      (issue_ack_o)
    );

    pending_tracker pending_tracker_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .issue_ack_i      (issue_ack_i),
        .flush_unissued_i (flush_unissued_i),
        .writes_rd_i      (writes_rd),
        .rd_fpr_i         (rd_fpr),
        .rs1_fpr_i        (rs1_fpr),
        .rs2_fpr_i        (rs2_fpr),
        .uses_rs3_i       (uses_rs3),
        .prs1_i           (prs1_o),
        .prs2_i           (prs2_o),
        .prs3_i           (prs3_o),
        .prd_i            (prd_o),
        .wb_valid_i       (wb_valid_i),
        .wb_preg_i        (wb_preg_i),
        .wb_fpr_i         (wb_fpr_i),
        .rs1_ready_o      (rs1_ready_o),
        .rs2_ready_o      (rs2_ready_o),
        .rs3_ready_o      (rs3_ready_o)
    );

endmodule

`default_nettype wire

//--- hw/issue_pkg.sv
// op_class_e has room for 8 classes; preg_t width follows ISSUE_PREG_W from the params header
`default_nettype none

`include "issue_params.svh"

package issue_pkg;

    // ------------------------------
    // operation classes
    // ------------------------------

    // one entry per supported class, everything else is illegal
    // register file use per class
    //   INT_RR     int  <- int, int
    //   FP_RR      fp   <- fp, fp
    //   FP_FMA     fp   <- fp, fp, fp
    //   FP_TO_INT  int  <- fp
    //   INT_TO_FP  fp   <- int
    typedef enum logic [2:0] {
        OPC_INT_RR    = 3'd0,
        OPC_FP_RR     = 3'd1,
        OPC_FP_FMA    = 3'd2,
        OPC_FP_TO_INT = 3'd3,
        OPC_INT_TO_FP = 3'd4,
        OPC_ILLEGAL   = 3'd7
    } op_class_e;

    // ------------------------------
    // renamed addresses
    // ------------------------------

    // name bit in the msb, architectural address below
    // the register file is not part of the address and
    // travels next to it as a separate select
    typedef logic [`ISSUE_PREG_W-1:0] preg_t;

endpackage

`default_nettype wire

//--- hw/pending_tracker.sv
// issue_ack_i must only pulse while the instruction is valid; one writeback per cycle
`default_nettype none

`include "issue_params.svh"

module pending_tracker (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                issue_ack_i,
    input  logic                flush_unissued_i,
    input  logic                writes_rd_i,
    input  logic                rd_fpr_i,
    input  logic                rs1_fpr_i,
    input  logic                rs2_fpr_i,
    input  logic                uses_rs3_i,
    input  issue_pkg::preg_t    prs1_i,
    input  issue_pkg::preg_t    prs2_i,
    input  issue_pkg::preg_t    prs3_i,
    input  issue_pkg::preg_t    prd_i,
    input  logic                wb_valid_i,
    input  issue_pkg::preg_t    wb_preg_i,
    input  logic                wb_fpr_i,
    output logic                rs1_ready_o,
    output logic                rs2_ready_o,
    output logic                rs3_ready_o
);

    localparam int unsigned NR_PREGS = 2 ** `ISSUE_PREG_W;

    // busy bit per physical register and file
    logic [NR_PREGS-1:0] busy_gpr_d, busy_gpr_q;
    logic [NR_PREGS-1:0] busy_fpr_d, busy_fpr_q;
    logic                set_busy;
    logic                rd_is_x0;

    // integer x0 under any name
    assign rd_is_x0 = ~rd_fpr_i & (prd_i[`ISSUE_AREG_W-1:0] == '0);
    assign set_busy = issue_ack_i & ~flush_unissued_i & writes_rd_i & ~rd_is_x0;

    // ------------------------------
    // source readiness
    // ------------------------------
    assign rs1_ready_o = rs1_fpr_i ? ~busy_fpr_q[prs1_i] : ~busy_gpr_q[prs1_i];
    assign rs2_ready_o = rs2_fpr_i ? ~busy_fpr_q[prs2_i] : ~busy_gpr_q[prs2_i];
    // unused rs3 never holds up issue
    assign rs3_ready_o = ~uses_rs3_i | ~busy_fpr_q[prs3_i];

    // ------------------------------
    // busy table update
    // ------------------------------
    always_comb begin
        busy_gpr_d = busy_gpr_q;
        busy_fpr_d = busy_fpr_q;

        // writeback first so a same-register set below wins
        if (wb_valid_i) begin
            if (wb_fpr_i) busy_fpr_d[wb_preg_i] = 1'b0;
            else          busy_gpr_d[wb_preg_i] = 1'b0;
        end

        if (set_busy) begin
            if (rd_fpr_i) busy_fpr_d[prd_i] = 1'b1;
            else          busy_gpr_d[prd_i] = 1'b1;
        end

        if (flush_i) begin
            busy_gpr_d = '0;
            busy_fpr_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_gpr_q <= '0;
            busy_fpr_q <= '0;
        end else begin
            busy_gpr_q <= busy_gpr_d;
            busy_fpr_q <= busy_fpr_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/re_name.sv
// one name bit per register only, so at most two writes to one register may be in flight
`default_nettype none

`include "issue_params.svh"

module re_name (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  logic                        flush_unissued_i,
    input  logic                        instr_valid_i,
    input  logic                        issue_ack_i,
    input  logic                        writes_rd_i,
    input  logic                        uses_rs3_i,
    input  logic                        rs1_fpr_i,
    input  logic                        rs2_fpr_i,
    input  logic                        rd_fpr_i,
    input  logic [`ISSUE_AREG_W-1:0]    rs1_i,
    input  logic [`ISSUE_AREG_W-1:0]    rs2_i,
    input  logic [`ISSUE_AREG_W-1:0]    rs3_i,
    input  logic [`ISSUE_AREG_W-1:0]    rd_i,
    output issue_pkg::preg_t            prs1_o,
    output issue_pkg::preg_t            prs2_o,
    output issue_pkg::preg_t            prs3_o,
    output issue_pkg::preg_t            prd_o,
    output logic                        issue_valid_o,
    output logic                        issue_ack_o
);

    localparam logic ENABLE = `ISSUE_ENABLE_RENAME;

    // strobes pass straight through
    assign issue_valid_o = instr_valid_i;
    assign issue_ack_o   = issue_ack_i;

    // name tables, one bit per architectural register
    logic [`ISSUE_NR_AREGS-1:0] name_gpr_d, name_gpr_q;
    logic [`ISSUE_NR_AREGS-1:0] name_fpr_d, name_fpr_q;

    // current name bits of the operands
    logic bit_rs1;
    logic bit_rs2;
    logic bit_rs3;
    logic bit_rd;
    // an issued write that really changes the tables
    logic do_toggle;

    // ------------------------------
    // renamed addresses
    // ------------------------------

    // sources read the table of their own register file
    assign bit_rs1 = rs1_fpr_i ? name_fpr_q[rs1_i] : name_gpr_q[rs1_i];
    assign bit_rs2 = rs2_fpr_i ? name_fpr_q[rs2_i] : name_gpr_q[rs2_i];
    // rs3 only exists in the FP file
    assign bit_rs3 = name_fpr_q[rs3_i] & uses_rs3_i;

    // destination shows the bit after renaming
    // integer x0 is never renamed
    assign bit_rd = rd_fpr_i ? ~name_fpr_q[rd_i]
                             : name_gpr_q[rd_i] ^ (rd_i != '0);

    assign prs1_o = {ENABLE & bit_rs1, rs1_i};
    assign prs2_o = {ENABLE & bit_rs2, rs2_i};
    assign prs3_o = {ENABLE & bit_rs3, rs3_i};
    assign prd_o  = {ENABLE & bit_rd, rd_i};

    // ------------------------------
    // table update
    // ------------------------------

    // ack only counts while valid
    assign do_toggle = instr_valid_i & issue_ack_i & ~flush_unissued_i & writes_rd_i;

    always_comb begin
        name_gpr_d = name_gpr_q;
        name_fpr_d = name_fpr_q;

        if (do_toggle) begin
            if (rd_fpr_i) begin
                name_fpr_d[rd_i] = ~name_fpr_q[rd_i];
            end else begin
                name_gpr_d[rd_i] = ~name_gpr_q[rd_i];
            end
        end

        // x0 is hardwired, its name never moves
        name_gpr_d[0] = 1'b0;

        // flush beats any acknowledge in the same cycle
        if (flush_i) begin
            name_gpr_d = '0;
            name_fpr_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            name_gpr_q <= '0;
            name_fpr_q <= '0;
        end else begin
            name_gpr_q <= name_gpr_d;
            name_fpr_q <= name_fpr_d;
        end
    end

endmodule

`default_nettype wire

//--- include/issue_params.svh
// sizes are fixed for a 32-entry register file per class; one name bit per register only
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// ------------------------------
// architectural register space
// ------------------------------

// address width of one architectural register file
`define ISSUE_AREG_W 5
// registers per file, integer and FP alike
`define ISSUE_NR_AREGS 32

// ------------------------------
// renamed register space
// ------------------------------

// one name bit on top of the architectural address
`define ISSUE_PREG_W 6
// set to 1'b0 to make every name bit read as zero
`define ISSUE_ENABLE_RENAME 1'b1

`endif

//--- issue_front.f
+incdir+include
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/instr_decoder.sv
hw/re_name.sv
hw/pending_tracker.sv
hw/issue_front.sv
tests/issue_front_props.sv
tests/issue_front_tb.sv

//--- tests/issue_front_props.sv
// checks only the re_name tables and strobes; needs a simulator with bind and SVA support
`default_nettype none

`include "issue_params.svh"

module issue_front_props (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  logic                        issue_ack_i,
    input  logic                        issue_ack_o,
    input  logic [`ISSUE_NR_AREGS-1:0]  name_gpr_q,
    input  logic [`ISSUE_NR_AREGS-1:0]  name_fpr_q
);
    timeunit 1ns;
    timeprecision 1ps;

    // x0 is hardwired and keeps name zero
    x0_name_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        name_gpr_q[0] == 1'b0)
        else $error("integer x0 name bit is set");

    // a flush leaves both tables clear one edge later
    flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> (name_gpr_q == '0) && (name_fpr_q == '0))
        else $error("name tables not clear after flush");

    // ack is a plain pass-through
    ack_through: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_ack_o == issue_ack_i)
        else $error("issue_ack_o differs from issue_ack_i");

endmodule

bind re_name issue_front_props props_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .issue_ack_i (issue_ack_i),
    .issue_ack_o (issue_ack_o),
    .name_gpr_q  (name_gpr_q),
    .name_fpr_q  (name_fpr_q)
);

`default_nettype wire

//--- tests/issue_front_tb.sv
// directed tests with a reference name/busy model; valid is always high with ack, one writeback at a time
`default_nettype none

`include "issue_params.svh"

module issue_front_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NR_PREGS   = 2 ** `ISSUE_PREG_W;
    localparam int WAIT_LIMIT = 16;

    logic                       clk;
    logic                       rst_n;
    isa_pkg::instr_word_t       instr;
    logic                       instr_valid;
    logic                       issue_ack;
    logic                       flush;
    logic                       flush_unissued;
    logic                       wb_valid;
    issue_pkg::preg_t           wb_preg;
    logic                       wb_fpr;
    issue_pkg::op_class_e       op;
    issue_pkg::preg_t           prs1;
    issue_pkg::preg_t           prs2;
    issue_pkg::preg_t           prs3;
    issue_pkg::preg_t           prd;
    logic                       issue_valid;
    logic                       issue_ack_out;
    logic                       rs1_ready;
    logic                       rs2_ready;
    logic                       rs3_ready;

    // reference model, name bit per register and busy bit per physical register
    logic [`ISSUE_NR_AREGS-1:0] ref_name_gpr;
    logic [`ISSUE_NR_AREGS-1:0] ref_name_fpr;
    logic [NR_PREGS-1:0]        ref_busy_gpr;
    logic [NR_PREGS-1:0]        ref_busy_fpr;

    int                         errors;
    int                         checks;
    int                         tests;
    int                         errors_at_start;

    issue_front issue_front_inst (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .instr_i          (instr),
        .instr_valid_i    (instr_valid),
        .issue_ack_i      (issue_ack),
        .flush_i          (flush),
        .flush_unissued_i (flush_unissued),
        .wb_valid_i       (wb_valid),
        .wb_preg_i        (wb_preg),
        .wb_fpr_i         (wb_fpr),
        .op_o             (op),
        .prs1_o           (prs1),
        .prs2_o           (prs2),
        .prs3_o           (prs3),
        .prd_o            (prd),
        .issue_valid_o    (issue_valid),
        .issue_ack_o      (issue_ack_out),
        .rs1_ready_o      (rs1_ready),
        .rs2_ready_o      (rs2_ready),
        .rs3_ready_o      (rs3_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check(input string tname, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected %0h actual %0h", tname, what, exp, act);
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string tname);
        tests++;
        $display("test %s: %s", tname, (errors == errors_at_start) ? "ok" : "errors");
    endtask

    // builds a word; fma goes through the fused view
    function automatic isa_pkg::instr_word_t encode(input issue_pkg::op_class_e cls,
            input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [4:0] rs3, input logic [4:0] rd);
        isa_pkg::instr_word_t w;
        w = '0;
        w.r.rs1 = rs1;
        w.r.rs2 = rs2;
        w.r.rd  = rd;
        case (cls)
            issue_pkg::OPC_INT_RR:    w.r.opcode = isa_pkg::OPC_OP;
            issue_pkg::OPC_FP_RR:     w.r.opcode = isa_pkg::OPC_OP_FP;
            issue_pkg::OPC_FP_TO_INT: begin
                w.r.opcode = isa_pkg::OPC_OP_FP;
                w.r.funct7 = isa_pkg::FN7_FMV_X_W;
            end
            issue_pkg::OPC_INT_TO_FP: begin
                w.r.opcode = isa_pkg::OPC_OP_FP;
                w.r.funct7 = isa_pkg::FN7_FMV_W_X;
            end
            issue_pkg::OPC_FP_FMA: begin
                w.r4.opcode = isa_pkg::OPC_FMADD;
                w.r4.rs3    = rs3;
            end
            // op-imm is outside the supported classes
            default:                  w.r.opcode = 7'b0010011;
        endcase
        return w;
    endfunction

    // register file use per class; moves cross files, illegal is all integer and no write
    task automatic class_use(input issue_pkg::op_class_e cls, output logic s1f,
            output logic s2f, output logic df, output logic u3, output logic wr);
        s1f = cls inside {issue_pkg::OPC_FP_RR, issue_pkg::OPC_FP_FMA, issue_pkg::OPC_FP_TO_INT};
        s2f = s1f;
        df  = cls inside {issue_pkg::OPC_FP_RR, issue_pkg::OPC_FP_FMA, issue_pkg::OPC_INT_TO_FP};
        u3  = (cls == issue_pkg::OPC_FP_FMA);
        wr  = (cls != issue_pkg::OPC_ILLEGAL);
    endtask

    function automatic logic name_of(input logic fpr, input logic [4:0] a);
        return `ISSUE_ENABLE_RENAME & (fpr ? ref_name_fpr[a] : ref_name_gpr[a]);
    endfunction

    function automatic logic busy_of(input logic fpr, input issue_pkg::preg_t p);
        return fpr ? ref_busy_fpr[p] : ref_busy_gpr[p];
    endfunction

    // one instruction for one cycle, outputs checked before the rising edge
    task automatic issue_one(input string tname, input issue_pkg::op_class_e cls,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rs3,
            input logic [4:0] rd, input logic ack, input logic fu);
        logic s1f, s2f, df, u3, wr, new_bit;
        issue_pkg::preg_t e1, e2, e3, ed;
        class_use(cls, s1f, s2f, df, u3, wr);
        @(negedge clk);
        instr          = encode(cls, rs1, rs2, rs3, rd);
        instr_valid    = 1'b1;
        issue_ack      = ack;
        flush_unissued = fu;
        #1;
        new_bit = df ? ~ref_name_fpr[rd] : ((rd != '0) & ~ref_name_gpr[rd]);
        e1 = {name_of(s1f, rs1), rs1};
        e2 = {name_of(s2f, rs2), rs2};
        e3 = u3 ? {name_of(1'b1, rs3), rs3} : '0;
        ed = {`ISSUE_ENABLE_RENAME & new_bit, rd};
        check(tname, "op", cls, op);
        check(tname, "issue_valid", 1, issue_valid);
        check(tname, "issue_ack", ack, issue_ack_out);
        if (wr) begin
            check(tname, "prs1", e1, prs1);
            check(tname, "prs2", e2, prs2);
            check(tname, "prs3", e3, prs3);
            check(tname, "prd", ed, prd);
            check(tname, "rs1_ready", !busy_of(s1f, e1), rs1_ready);
            check(tname, "rs2_ready", !busy_of(s2f, e2), rs2_ready);
            check(tname, "rs3_ready", !u3 || !ref_busy_fpr[e3], rs3_ready);
        end
        @(negedge clk);
        instr_valid    = 1'b0;
        issue_ack      = 1'b0;
        flush_unissued = 1'b0;
        // mirror the table update of the edge just passed
        if (ack && !fu && wr && (df || rd != '0)) begin
            if (df) begin
                ref_name_fpr[rd] = ~ref_name_fpr[rd];
                ref_busy_fpr[ed] = 1'b1;
            end else begin
                ref_name_gpr[rd] = ~ref_name_gpr[rd];
                ref_busy_gpr[ed] = 1'b1;
            end
        end
    endtask

    task automatic writeback(input issue_pkg::preg_t p, input logic fpr);
        @(negedge clk);
        wb_valid = 1'b1;
        wb_preg  = p;
        wb_fpr   = fpr;
        @(negedge clk);
        wb_valid = 1'b0;
        if (fpr) ref_busy_fpr[p] = 1'b0;
        else     ref_busy_gpr[p] = 1'b0;
    endtask

    // holds a reader of integer rs1 until it reports ready
    task automatic wait_rs1_ready(input string tname, input logic [4:0] rs1);
        int n;
        n = 0;
        @(negedge clk);
        instr       = encode(issue_pkg::OPC_INT_RR, rs1, 5'd0, 5'd0, 5'd1);
        instr_valid = 1'b1;
        #1;
        while (!rs1_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            n++;
        end
        instr_valid = 1'b0;
        if (!rs1_ready) begin
            errors++;
            $display("%s: rs1 did not become ready within %0d cycles", tname, WAIT_LIMIT);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_reset_names();
        int unsigned r;
        issue_pkg::op_class_e cls;
        start_test();
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            cls = issue_pkg::op_class_e'(r % 5);
            issue_one("reset_names", cls, r[7:3], r[12:8], r[17:13], r[22:18], 1'b0, 1'b0);
        end
        end_test("reset_names");
    endtask

    task automatic test_int_toggle();
        start_test();
        issue_one("int_toggle", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd5, 1'b1, 1'b0);
        issue_one("int_toggle", issue_pkg::OPC_INT_RR, 5'd5, 5'd5, 5'd0, 5'd6, 1'b0, 1'b0);
        issue_one("int_toggle", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd5, 1'b1, 1'b0);
        issue_one("int_toggle", issue_pkg::OPC_INT_RR, 5'd5, 5'd2, 5'd0, 5'd6, 1'b0, 1'b0);
        end_test("int_toggle");
    endtask

    task automatic test_x0_unissued();
        start_test();
        issue_one("x0_unissued", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd0, 1'b1, 1'b0);
        issue_one("x0_unissued", issue_pkg::OPC_FP_TO_INT, 5'd1, 5'd2, 5'd0, 5'd0, 1'b1, 1'b0);
        issue_one("x0_unissued", issue_pkg::OPC_INT_RR, 5'd0, 5'd0, 5'd0, 5'd3, 1'b0, 1'b0);
        // flushed before issue, table must stay put
        issue_one("x0_unissued", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd7, 1'b1, 1'b1);
        issue_one("x0_unissued", issue_pkg::OPC_INT_RR, 5'd7, 5'd7, 5'd0, 5'd3, 1'b0, 1'b0);
        end_test("x0_unissued");
    endtask

    task automatic test_fp_int_split();
        start_test();
        issue_one("fp_int_split", issue_pkg::OPC_FP_RR, 5'd1, 5'd2, 5'd0, 5'd3, 1'b1, 1'b0);
        issue_one("fp_int_split", issue_pkg::OPC_INT_RR, 5'd3, 5'd3, 5'd0, 5'd8, 1'b0, 1'b0);
        issue_one("fp_int_split", issue_pkg::OPC_FP_FMA, 5'd1, 5'd2, 5'd3, 5'd4, 1'b1, 1'b0);
        issue_one("fp_int_split", issue_pkg::OPC_FP_TO_INT, 5'd4, 5'd3, 5'd0, 5'd9, 1'b1, 1'b0);
        issue_one("fp_int_split", issue_pkg::OPC_INT_TO_FP, 5'd9, 5'd0, 5'd0, 5'd10, 1'b1, 1'b0);
        issue_one("fp_int_split", issue_pkg::OPC_ILLEGAL, 5'd1, 5'd2, 5'd0, 5'd11, 1'b1, 1'b0);
        issue_one("fp_int_split", issue_pkg::OPC_INT_RR, 5'd11, 5'd10, 5'd0, 5'd8, 1'b0, 1'b0);
        issue_one("fp_int_split", issue_pkg::OPC_FP_RR, 5'd11, 5'd10, 5'd0, 5'd8, 1'b0, 1'b0);
        end_test("fp_int_split");
    endtask

    task automatic test_flush();
        start_test();
        // two writes to x12 leave both of its physical registers busy
        issue_one("flush", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd12, 1'b1, 1'b0);
        issue_one("flush", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd12, 1'b1, 1'b0);
        issue_one("flush", issue_pkg::OPC_FP_RR, 5'd1, 5'd2, 5'd0, 5'd12, 1'b1, 1'b0);
        // flush together with an acknowledged write
        @(negedge clk);
        instr       = encode(issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd13);
        instr_valid = 1'b1;
        issue_ack   = 1'b1;
        flush       = 1'b1;
        @(negedge clk);
        instr_valid  = 1'b0;
        issue_ack    = 1'b0;
        flush        = 1'b0;
        ref_name_gpr = '0;
        ref_name_fpr = '0;
        ref_busy_gpr = '0;
        ref_busy_fpr = '0;
        issue_one("flush", issue_pkg::OPC_INT_RR, 5'd12, 5'd13, 5'd0, 5'd1, 1'b0, 1'b0);
        issue_one("flush", issue_pkg::OPC_FP_FMA, 5'd12, 5'd4, 5'd3, 5'd1, 1'b0, 1'b0);
        end_test("flush");
    endtask

    task automatic test_busy_ready();
        start_test();
        issue_one("busy_ready", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd14, 1'b1, 1'b0);
        issue_one("busy_ready", issue_pkg::OPC_INT_RR, 5'd14, 5'd14, 5'd0, 5'd1, 1'b0, 1'b0);
        check("busy_ready", "rs1 busy", 0, rs1_ready);
        writeback({1'b1, 5'd14}, 1'b0);
        wait_rs1_ready("busy_ready", 5'd14);
        issue_one("busy_ready", issue_pkg::OPC_INT_RR, 5'd14, 5'd14, 5'd0, 5'd1, 1'b0, 1'b0);
        // fp producer held by rs3 of an fma, then released
        issue_one("busy_ready", issue_pkg::OPC_FP_RR, 5'd1, 5'd2, 5'd0, 5'd0, 1'b1, 1'b0);
        issue_one("busy_ready", issue_pkg::OPC_FP_FMA, 5'd1, 5'd2, 5'd0, 5'd16, 1'b0, 1'b0);
        writeback({1'b1, 5'd0}, 1'b1);
        issue_one("busy_ready", issue_pkg::OPC_FP_FMA, 5'd1, 5'd2, 5'd0, 5'd16, 1'b0, 1'b0);
        // second write of f0 leaves the address of an unused rs3 busy
        issue_one("busy_ready", issue_pkg::OPC_FP_RR, 5'd1, 5'd2, 5'd0, 5'd0, 1'b1, 1'b0);
        issue_one("busy_ready", issue_pkg::OPC_INT_RR, 5'd1, 5'd2, 5'd0, 5'd17, 1'b0, 1'b0);
        check("busy_ready", "unused rs3 ready", 1, rs3_ready);
        end_test("busy_ready");
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        instr = '0;
        instr_valid = 1'b0;
        issue_ack = 1'b0;
        flush = 1'b0;
        flush_unissued = 1'b0;
        wb_valid = 1'b0;
        wb_preg = '0;
        wb_fpr = 1'b0;
        ref_name_gpr = '0;
        ref_name_fpr = '0;
        ref_busy_gpr = '0;
        ref_busy_fpr = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        void'($urandom(53124));
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_names();
        test_int_toggle();
        test_x0_unissued();
        test_fp_int_split();
        test_flush();
        test_busy_ready();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
